// File: include/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// Entries in each NI FIFO
`define NOC_FIFO_DEPTH 4

`define NOC_NUM_GPUS 4

// Group field of this leaf cluster
`define NOC_LOCAL_GROUP 1

`define NOC_MAX_GPU_ID 32

`endif

// File: hdl/noc_pkg.sv
`default_nettype none
`include "noc_params.svh"

package noc_pkg;

    typedef struct packed {
        logic [5:0] dest_id;
        logic [9:0] payload;
    } gpu_flit_t;

    typedef struct packed {
        logic [3:0] group;
        logic [1:0] leaf;
        logic [9:0] payload;
    } route_flit_t;

    // GPU 1 lands on address 4, i.e. group 1 leaf 0
    function automatic logic [5:0] id_to_addr(input logic [5:0] id);
        if (id >= 6'd1 && id <= 6'(`NOC_MAX_GPU_ID)) begin
            return id + 6'd3;
        end
        return 6'd0;
    endfunction

    function automatic logic [5:0] addr_to_id(input logic [5:0] addr);
        if (addr >= 6'd4 && addr <= 6'(`NOC_MAX_GPU_ID + 3)) begin
            return addr - 6'd3;
        end
        return 6'd0;
    endfunction

endpackage

`default_nettype wire

// File: hdl/flit_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "noc_params.svh"

module flit_fifo #(
    parameter type T_ENTRY = logic [15:0],
    parameter int DEPTH = `NOC_FIFO_DEPTH
) (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   push,
    input  wire T_ENTRY push_data,
    input  wire logic   pop,
    output T_ENTRY      pop_data,
    output logic        full,
    output logic        empty
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T_ENTRY mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PW-1:0] bump(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == CW'(DEPTH));
    assign empty = (count == '0);

    // Show-ahead read
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("flit_fifo: push while full");

    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("flit_fifo: pop while empty");

endmodule

`default_nettype wire

// File: hdl/gpu_ni.sv
`timescale 1ns/10ps
`default_nettype none
`include "noc_params.svh"

module gpu_ni #(
    parameter int GPU_ID = 1
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire noc_pkg::gpu_flit_t   gpu_in,
    input  wire logic                 gpu_in_valid,
    output logic                      gpu_in_ready,
    output noc_pkg::gpu_flit_t        gpu_out,
    output logic                      gpu_out_valid,
    input  wire logic                 gpu_out_ready,
    output noc_pkg::route_flit_t      route_out,
    output logic                      route_out_valid,
    input  wire logic                 route_ready,
    input  wire noc_pkg::route_flit_t route_in,
    input  wire logic                 route_in_valid
);

    localparam logic [5:0] OWN_ADDR = noc_pkg::id_to_addr(6'(GPU_ID));

    logic [5:0] dest_addr;
    logic [5:0] in_addr;
    noc_pkg::route_flit_t send_entry;
    noc_pkg::route_flit_t send_head;
    logic send_push;
    logic send_pop;
    logic send_full;
    logic send_empty;
    noc_pkg::gpu_flit_t recv_entry;
    noc_pkg::gpu_flit_t recv_head;
    logic recv_push;
    logic recv_pop;
    logic recv_full;
    logic recv_empty;

    // Send path: ID to routing address on the way in
    assign dest_addr = noc_pkg::id_to_addr(gpu_in.dest_id);
    assign send_entry = '{group: dest_addr[5:2], leaf: dest_addr[1:0], payload: gpu_in.payload};
    assign gpu_in_ready = !send_full;
    assign send_push = gpu_in_valid && !send_full;
    // Router ready only drops a cycle after it takes the pulse
    assign send_pop = route_ready && !route_out_valid && !send_empty;

    flit_fifo #(
        .T_ENTRY (noc_pkg::route_flit_t),
        .DEPTH   (`NOC_FIFO_DEPTH)
    ) i_send_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (send_push),
        .push_data (send_entry),
        .pop       (send_pop),
        .pop_data  (send_head),
        .full      (send_full),
        .empty     (send_empty)
    );

    // Receive path keeps only flits for this GPU, and drops when full
    assign in_addr = {route_in.group, route_in.leaf};
    assign recv_entry = '{dest_id: noc_pkg::addr_to_id(in_addr), payload: route_in.payload};
    assign recv_push = route_in_valid && (in_addr == OWN_ADDR) && !recv_full;
    assign recv_pop = gpu_out_ready && !recv_empty;

    flit_fifo #(
        .T_ENTRY (noc_pkg::gpu_flit_t),
        .DEPTH   (`NOC_FIFO_DEPTH)
    ) i_recv_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (recv_push),
        .push_data (recv_entry),
        .pop       (recv_pop),
        .pop_data  (recv_head),
        .full      (recv_full),
        .empty     (recv_empty)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            route_out_valid <= 1'b0;
            gpu_out_valid <= 1'b0;
        end else begin
            route_out_valid <= send_pop;
            gpu_out_valid <= recv_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (send_pop) begin
            route_out <= send_head;
        end
        if (recv_pop) begin
            gpu_out <= recv_head;
        end
    end

endmodule

`default_nettype wire

// File: hdl/leaf_router.sv
`timescale 1ns/10ps
`default_nettype none
`include "noc_params.svh"

module leaf_router (
    input  wire logic                                      clk,
    input  wire logic                                      reset,
    input  wire noc_pkg::route_flit_t [`NOC_NUM_GPUS-1:0] in_flit,
    input  wire logic [`NOC_NUM_GPUS-1:0]                  in_valid,
    output logic [`NOC_NUM_GPUS-1:0]                       in_ready,
    output noc_pkg::route_flit_t [`NOC_NUM_GPUS-1:0]       out_flit,
    output logic [`NOC_NUM_GPUS-1:0]                       out_valid
);

    localparam int N = `NOC_NUM_GPUS;
    localparam int IW = $clog2(N);

    noc_pkg::route_flit_t [N-1:0] hold_flit;
    logic [N-1:0] hold_valid;
    logic [N-1:0] hold_ok;
    logic [N-1:0] req [N];          // [output][input]
    logic [N-1:0] grant [N];        // [output][input]
    logic [N-1:0] grant_by_in [N];  // [input][output]
    logic [IW-1:0] win_idx [N];
    logic [IW-1:0] rr_ptr [N];      // input with top priority next

    assign in_ready = ~hold_valid;

    // Only the local group is routable here, address 0 never is
    always_comb begin
        for (int i = 0; i < N; i++) begin
            hold_ok[i] = (hold_flit[i].group == 4'(`NOC_LOCAL_GROUP))
                && ({hold_flit[i].group, hold_flit[i].leaf} != 6'd0);
        end
    end

    always_comb begin
        for (int o = 0; o < N; o++) begin
            for (int i = 0; i < N; i++) begin
                req[o][i] = hold_valid[i] && hold_ok[i] && (hold_flit[i].leaf == 2'(o));
            end
        end
    end

    always_comb begin
        int idx;
        logic found;
        for (int o = 0; o < N; o++) begin
            grant[o] = '0;
            win_idx[o] = '0;
            found = 1'b0;
            for (int k = 0; k < N; k++) begin
                idx = (int'(rr_ptr[o]) + k) % N;
                if (!found && req[o][idx]) begin
                    grant[o][idx] = 1'b1;
                    win_idx[o] = IW'(idx);
                    found = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            for (int o = 0; o < N; o++) begin
                grant_by_in[i][o] = grant[o][i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hold_valid <= '0;
            out_valid <= '0;
            for (int o = 0; o < N; o++) begin
                rr_ptr[o] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (!hold_valid[i]) begin
                    hold_valid[i] <= in_valid[i];
                end else if (!hold_ok[i] || (|grant_by_in[i])) begin
                    // Freed on grant or discard
                    hold_valid[i] <= 1'b0;
                end
            end
            for (int o = 0; o < N; o++) begin
                out_valid[o] <= |grant[o];
                if (|grant[o]) begin
                    rr_ptr[o] <= (win_idx[o] == IW'(N - 1)) ? '0 : win_idx[o] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (in_valid[i] && !hold_valid[i]) begin
                hold_flit[i] <= in_flit[i];
            end
        end
        for (int o = 0; o < N; o++) begin
            if (|grant[o]) begin
                out_flit[o] <= hold_flit[win_idx[o]];
            end
        end
    end

    // A flit only arrives while its holding register is free
    for (genvar i = 0; i < N; i++) begin : g_hold_chk
        assert property (@(posedge clk) disable iff (reset) in_valid[i] |-> !hold_valid[i])
            else $error("leaf_router: input %0d overrun while holding a flit", i);
    end

endmodule

`default_nettype wire

// File: hdl/gpu_cluster.sv
`timescale 1ns/10ps
`default_nettype none
`include "noc_params.svh"

module gpu_cluster (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    input  wire noc_pkg::gpu_flit_t [`NOC_NUM_GPUS-1:0] gpu_in,
    input  wire logic [`NOC_NUM_GPUS-1:0]                gpu_in_valid,
    output logic [`NOC_NUM_GPUS-1:0]                     gpu_in_ready,
    output noc_pkg::gpu_flit_t [`NOC_NUM_GPUS-1:0]       gpu_out,
    output logic [`NOC_NUM_GPUS-1:0]                     gpu_out_valid,
    input  wire logic [`NOC_NUM_GPUS-1:0]                gpu_out_ready
);

    localparam int N = `NOC_NUM_GPUS;

    noc_pkg::route_flit_t [N-1:0] up_flit;
    logic [N-1:0] up_valid;
    logic [N-1:0] up_ready;
    noc_pkg::route_flit_t [N-1:0] down_flit;
    logic [N-1:0] down_valid;

    // GPU g+1 sits on leaf g, so NI g also takes router output g
    for (genvar g = 0; g < N; g++) begin : g_ni
        gpu_ni #(
            .GPU_ID (g + 1)
        ) i_ni (
            .clk             (clk),
            .reset           (reset),
            .gpu_in          (gpu_in[g]),
            .gpu_in_valid    (gpu_in_valid[g]),
            .gpu_in_ready    (gpu_in_ready[g]),
            .gpu_out         (gpu_out[g]),
            .gpu_out_valid   (gpu_out_valid[g]),
            .gpu_out_ready   (gpu_out_ready[g]),
            .route_out       (up_flit[g]),
            .route_out_valid (up_valid[g]),
            .route_ready     (up_ready[g]),
            .route_in        (down_flit[g]),
            .route_in_valid  (down_valid[g])
        );
    end

    leaf_router i_router (
        .clk       (clk),
        .reset     (reset),
        .in_flit   (up_flit),
        .in_valid  (up_valid),
        .in_ready  (up_ready),
        .out_flit  (down_flit),
        .out_valid (down_valid)
    );

endmodule

`default_nettype wire

// File: verif/tb_gpu_cluster.sv
`timescale 1ns/10ps
`default_nettype none
`include "noc_params.svh"

module tb_gpu_cluster;

    localparam int N = `NOC_NUM_GPUS;
    localparam int CASE_CYCLES = 40;
    localparam int DROP_WAIT = 8;

    typedef struct packed {
        logic [1:0] src;
        logic [5:0] dest;
        logic [9:0] payload;
        logic [7:0] stall;
        logic       deliver;
    } case_t;

    typedef struct packed {
        logic [1:0]         src;
        noc_pkg::gpu_flit_t flit;
    } expect_t;

    logic clk;
    logic reset;
    noc_pkg::gpu_flit_t [N-1:0] gpu_in;
    logic [N-1:0] gpu_in_valid;
    logic [N-1:0] gpu_in_ready;
    noc_pkg::gpu_flit_t [N-1:0] gpu_out;
    logic [N-1:0] gpu_out_valid;
    logic [N-1:0] gpu_out_ready;

    case_t cases[$];
    expect_t exp_q [N][$];
    case_t pending [N];
    int next_case [N];
    int wait_left [N];
    int stall_left [N];
    logic [N-1:0] sending;
    int drops;
    int seed;
    bit cases_loaded;

    gpu_cluster i_dut (
        .clk           (clk),
        .reset         (reset),
        .gpu_in        (gpu_in),
        .gpu_in_valid  (gpu_in_valid),
        .gpu_in_ready  (gpu_in_ready),
        .gpu_out       (gpu_out),
        .gpu_out_valid (gpu_out_valid),
        .gpu_out_ready (gpu_out_ready)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_flit(input string name, input noc_pkg::gpu_flit_t got,
                                input noc_pkg::gpu_flit_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR: time %0t, %s got %h, expected %h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR: time %0t, %s got %b, expected %b",
                $time, name, got, exp));
        end
    endtask

    function automatic int find_case(input int s, input int from);
        for (int i = from; i < cases.size(); i++) begin
            if (int'(cases[i].src) == s) begin
                return i;
            end
        end
        return cases.size();
    endfunction

    task automatic load_cases();
        int fd;
        int n;
        int src;
        int dest;
        int payload;
        int stall;
        int deliver;
        logic [1023:0] line;
        case_t c;
        fd = $fopen("verif/noc_cases.txt", "r");
        if (fd == 0) begin
            abort_run("ERROR: cannot open verif/noc_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%d %d %h %d %d", src, dest, payload, stall, deliver);
                if (n != 5) begin
                    // Comment line or end of file
                    n = $fgets(line, fd);
                end else if (src < 1 || src > N || dest < 0 || dest > 63
                        || payload > 1023 || stall > 255) begin
                    abort_run($sformatf("ERROR: case %0d has a field out of range",
                        cases.size()));
                end else if ((deliver != 0) != (dest >= 1 && dest <= N)) begin
                    // Only GPUs 1 to 4 sit in group 1
                    abort_run($sformatf("ERROR: case %0d expects the wrong fate for ID %0d",
                        cases.size(), dest));
                end else begin
                    c.src = 2'(src - 1);
                    c.dest = 6'(dest);
                    c.payload = 10'(payload);
                    c.stall = 8'(stall);
                    c.deliver = (deliver != 0);
                    cases.push_back(c);
                end
            end
            $fclose(fd);
        end
        cases_loaded = 1'b1;
    endtask

    task automatic watch_outputs();
        int hit;
        logic [1:0] sender;
        for (int d = 0; d < N; d++) begin
            if (gpu_out_valid[d]) begin
                if (exp_q[d].size() == 0) begin
                    abort_run($sformatf("ERROR: GPU %0d received a flit nobody sent to it",
                        d + 1));
                end else begin
                    // Payloads are unique, so the payload names the sender
                    hit = 0;
                    for (int i = exp_q[d].size() - 1; i >= 0; i--) begin
                        if (exp_q[d][i].flit.payload == gpu_out[d].payload) begin
                            hit = i;
                        end
                    end
                    // Flits of one sender come out oldest first
                    sender = exp_q[d][hit].src;
                    for (int i = hit - 1; i >= 0; i--) begin
                        if (exp_q[d][i].src == sender) begin
                            hit = i;
                        end
                    end
                    compare_flit($sformatf("gpu_out[%0d]", d), gpu_out[d], exp_q[d][hit].flit);
                    exp_q[d].delete(hit);
                end
            end
        end
    endtask

    task automatic step_sources();
        noc_pkg::gpu_flit_t flit;
        case_t c;
        bit room;
        int d;
        for (int s = 0; s < N; s++) begin
            if (sending[s]) begin
                if (gpu_in_ready[s]) begin
                    sending[s] = 1'b0;
                    gpu_in_valid[s] <= 1'b0;
                    wait_left[s] = $random(seed) & 3;
                    if (!pending[s].deliver) begin
                        drops++;
                        wait_left[s] += DROP_WAIT;
                    end
                end
            end else if (wait_left[s] > 0) begin
                wait_left[s]--;
            end else if (next_case[s] < cases.size()) begin
                c = cases[next_case[s]];
                d = int'(c.dest) - 1;
                // No more flits outstanding per destination than its receive FIFO holds
                if (c.deliver) begin
                    room = (exp_q[d].size() < `NOC_FIFO_DEPTH);
                end else begin
                    room = 1'b1;
                end
                if (room) begin
                    pending[s] = c;
                    next_case[s] = find_case(s, next_case[s] + 1);
                    gpu_in[s] <= '{dest_id: c.dest, payload: c.payload};
                    gpu_in_valid[s] <= 1'b1;
                    sending[s] = 1'b1;
                    if (c.deliver) begin
                        flit.dest_id = c.dest;
                        flit.payload = c.payload;
                        exp_q[d].push_back('{src: 2'(s), flit: flit});
                        if (stall_left[d] < int'(c.stall)) begin
                            stall_left[d] = int'(c.stall);
                        end
                    end
                end
            end
        end
    endtask

    task automatic drive_ready();
        for (int d = 0; d < N; d++) begin
            gpu_out_ready[d] <= (stall_left[d] == 0);
            if (stall_left[d] > 0) begin
                stall_left[d]--;
            end
        end
    endtask

    function automatic bit sources_idle();
        for (int s = 0; s < N; s++) begin
            if (sending[s] || wait_left[s] != 0 || next_case[s] < cases.size()) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic int flits_outstanding();
        int total;
        total = 0;
        for (int d = 0; d < N; d++) begin
            total += exp_q[d].size();
        end
        return total;
    endfunction

    initial begin
        wait (cases_loaded);
        repeat (CASE_CYCLES * cases.size() + 20) @(posedge clk);
        abort_run("ERROR: timeout, flits still in flight when the cycle budget ran out");
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        gpu_in = '0;
        gpu_in_valid = '0;
        gpu_out_ready = '1;
        sending = '0;
        drops = 0;
        seed = 32;
        for (int s = 0; s < N; s++) begin
            wait_left[s] = 0;
            stall_left[s] = 0;
        end
        load_cases();
        for (int s = 0; s < N; s++) begin
            next_case[s] = find_case(s, 0);
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int d = 0; d < N; d++) begin
            check_level($sformatf("gpu_in_ready[%0d]", d), gpu_in_ready[d], 1'b1);
            check_level($sformatf("gpu_out_valid[%0d]", d), gpu_out_valid[d], 1'b0);
        end
        while (!sources_idle() || flits_outstanding() != 0) begin
            @(posedge clk);
            watch_outputs();
            step_sources();
            drive_ready();
        end
        // Late or stray deliveries still show up here
        repeat (10) begin
            @(posedge clk);
            watch_outputs();
            drive_ready();
        end
        $display("%0d cases run, %0d flits dropped by the address map", cases.size(), drops);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
hdl/noc_pkg.sv
hdl/flit_fifo.sv
hdl/gpu_ni.sv
hdl/leaf_router.sv
hdl/gpu_cluster.sv
verif/tb_gpu_cluster.sv

// File: Makefile
BIN = obj_dir/Vtb_gpu_cluster

.PHONY: all run check clean

all: run

$(BIN): compile.f include/noc_params.svh hdl/noc_pkg.sv hdl/flit_fifo.sv hdl/gpu_ni.sv \
        hdl/leaf_router.sv hdl/gpu_cluster.sv verif/tb_gpu_cluster.sv
	verilator --binary --assert -Wno-fatal --top-module tb_gpu_cluster -f compile.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

check:
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/noc_cases.txt
# src dest payload stall expect, one flit per line, payload in hex
# stall holds gpu_out_ready of the destination low for that many cycles, expect 1 means delivered
1 2 001 0 1
2 3 002 0 1
3 4 003 0 1
4 1 004 0 1
1 1 005 0 1
2 0 006 0 0
3 5 007 0 0
4 32 008 0 0
1 3 010 0 1
2 3 011 0 1
4 3 012 0 1
1 3 013 6 1
2 4 014 5 1
3 4 015 8 1
4 4 016 0 1
